// ==== hw/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// general register length, also the address width
`define LSU_GRLEN 32

// operation code width from the execute stage
`define LSU_OP_BITS 4

// destination register tag
`define LSU_RD_BITS 5

// one strobe per byte of a word
`define LSU_STRB_BITS 4

`endif

// ==== hw/lsu_op_pkg.sv ====
`include "lsu_config.svh"

package lsu_op_pkg;

   // operation codes as sent by the execute stage
   typedef enum logic [`LSU_OP_BITS-1:0] {
      nop   = 'd0,
      ld_b  = 'd1,
      ld_h  = 'd2,
      ld_w  = 'd3,
      ld_bu = 'd4,
      ld_hu = 'd5,
      st_b  = 'd6,
      st_h  = 'd7,
      st_w  = 'd8,
      ll_w  = 'd9,
      sc_w  = 'd10
   } lsu_op_e;

   // access size
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } lsu_size_e;

   // decoded access, one record per operation
   typedef struct packed {
      lsu_size_e size;
      // zero extend the loaded lane
      logic      zext;
      // memory write, sc included
      logic      store;
      logic      ll;
      logic      sc;
      // anything but nop
      logic      mem;
   } lsu_access_t;

endpackage

// ==== hw/lsu_mem_pkg.sv ====
`include "lsu_config.svh"

package lsu_mem_pkg;

   import lsu_op_pkg::*;

   // fields of one data memory request
   typedef struct packed {
      logic [`LSU_GRLEN-1:0]     addr;
      logic                      wr;
      logic [`LSU_STRB_BITS-1:0] strb;
      logic [`LSU_GRLEN-1:0]     wdata;
      logic                      ll;
      logic                      sc;
   } lsu_mem_req_t;

   // what the memory stage keeps of a dispatched operation
   typedef struct packed {
      lsu_access_t             access;
      // low address bits select the load lane
      logic [1:0]              addr_lo;
      logic [`LSU_RD_BITS-1:0] rd;
      logic                    wen;
      // misaligned, no request was raised
      logic                    ale;
   } lsu_track_t;

endpackage

// ==== hw/lsu_op_decode.sv ====
`include "lsu_config.svh"

module lsu_op_decode
   import lsu_op_pkg::*;
(
   input  lsu_op_e     op,
   output lsu_access_t access
);

   always_comb begin
      // nop decodes to no memory access
      access = '{size: size_byte, default: 1'b0};
      case (op)
         ld_b: begin
            access.mem = 1'b1;
         end
         ld_bu: begin
            access.mem  = 1'b1;
            access.zext = 1'b1;
         end
         ld_h: begin
            access.mem  = 1'b1;
            access.size = size_half;
         end
         ld_hu: begin
            access.mem  = 1'b1;
            access.size = size_half;
            access.zext = 1'b1;
         end
         ld_w: begin
            access.mem  = 1'b1;
            access.size = size_word;
         end
         st_b: begin
            access.mem   = 1'b1;
            access.store = 1'b1;
         end
         st_h: begin
            access.mem   = 1'b1;
            access.size  = size_half;
            access.store = 1'b1;
         end
         st_w: begin
            access.mem   = 1'b1;
            access.size  = size_word;
            access.store = 1'b1;
         end
         ll_w: begin
            access.mem  = 1'b1;
            access.size = size_word;
            access.ll   = 1'b1;
         end
         sc_w: begin
            // sc writes memory, result is only the success bit
            access.mem   = 1'b1;
            access.size  = size_word;
            access.store = 1'b1;
            access.sc    = 1'b1;
         end
         default: begin
            access.mem = 1'b0;
         end
      endcase
   end

endmodule

// ==== hw/lsu_issue.sv ====
`include "lsu_config.svh"

module lsu_issue
   import lsu_op_pkg::*;
   import lsu_mem_pkg::*;
(
   input  lsu_op_e               lsu_op,
   input  logic [`LSU_GRLEN-1:0] base,
   input  logic [`LSU_GRLEN-1:0] offset,
   input  logic [`LSU_GRLEN-1:0] wdata,
   output lsu_access_t           access,
   output lsu_mem_req_t          mem_req,
   output logic                  ale
);

   logic [`LSU_GRLEN-1:0]     addr;
   logic [1:0]                shift;
   logic [`LSU_STRB_BITS-1:0] strb;
   logic [`LSU_GRLEN-1:0]     wdata_rep;

   lsu_op_decode lsu_op_decode_i (
      .op     (lsu_op),
      .access (access)
   );

   assign addr  = base + offset;
   assign shift = addr[1:0];

   // halfword needs even address, word, ll and sc need word alignment
   assign ale = access.mem &&
                ((access.size == size_half && shift[0]) ||
                 (access.size == size_word && shift != 2'd0));

   always_comb begin
      strb      = '0;
      wdata_rep = '0;
      if (access.store) begin
         case (access.size)
            size_byte: begin
               strb      = 4'b0001 << shift;
               wdata_rep = {4{wdata[7:0]}};
            end
            size_half: begin
               strb      = 4'b0011 << shift;
               wdata_rep = {2{wdata[15:0]}};
            end
            default: begin
               strb      = 4'b1111;
               wdata_rep = wdata;
            end
         endcase
      end
   end

   // loads leave strobes and data at zero
   assign mem_req.addr  = addr;
   assign mem_req.wr    = access.store;
   assign mem_req.strb  = strb;
   assign mem_req.wdata = wdata_rep;
   assign mem_req.ll    = access.ll;
   assign mem_req.sc    = access.sc;

endmodule

// ==== hw/lsu_mem_request.sv ====
`include "lsu_config.svh"

module lsu_mem_request
   import lsu_mem_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         valid_e,
   input  logic         ale_e,
   input  lsu_mem_req_t mem_req_e,
   input  logic         data_addr_ok,
   input  logic         data_data_ok_m,
   output logic         data_req,
   output lsu_mem_req_t mem_req,
   output logic         data_recv,
   output logic         lsu_addr_finish
);

   logic issue_e;
   logic req_q;
   logic recv_q;

   // a dispatch that passed the alignment check
   assign issue_e = valid_e & ~ale_e;

   always_ff @(posedge clk) begin
      if (reset) begin
         req_q  <= 1'b0;
         recv_q <= 1'b0;
      end else begin
         // held until data returns
         req_q  <= (req_q & ~data_data_ok_m) | issue_e;
         // address accepted, data still outstanding
         recv_q <= (recv_q | (req_q & data_addr_ok)) & ~data_data_ok_m;
      end
   end

   // fields only change on an issued dispatch
   always_ff @(posedge clk) begin
      if (issue_e) begin
         mem_req <= mem_req_e;
      end
   end

   assign data_req        = req_q;
   assign data_recv       = recv_q;
   assign lsu_addr_finish = req_q & data_addr_ok;

   // memory sees a stable request until the return
   a_req_stable: assert property (
      @(posedge clk) disable iff (reset)
      data_req && !data_data_ok_m |=> $stable(mem_req)
   ) else $error("request fields changed while the request was held");

   // execute stage waits for the finish before the next dispatch
   a_no_dispatch: assert property (
      @(posedge clk) disable iff (reset)
      data_req && !data_data_ok_m |-> !valid_e
   ) else $error("dispatch while a memory request was pending");

endmodule

// ==== hw/lsu_writeback.sv ====
`include "lsu_config.svh"

module lsu_writeback
   import lsu_op_pkg::*;
   import lsu_mem_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    valid_e,
   input  lsu_track_t              track_e,
   input  logic                    data_data_ok_m,
   input  logic [`LSU_GRLEN-1:0]   data_rdata_m,
   input  logic                    data_scsucceed,
   output logic [`LSU_GRLEN-1:0]   read_result_m,
   output logic                    lsu_finish_m,
   output logic [`LSU_RD_BITS-1:0] lsu_ecl_rd_m,
   output logic                    lsu_ecl_wen_m
);

   lsu_track_t  track_m;
   logic        valid_m;
   logic [7:0]  lane_b;
   logic [15:0] lane_h;
   logic        sign_b;
   logic        sign_h;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_m <= 1'b0;
      end else begin
         valid_m <= valid_e;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_e) begin
         track_m <= track_e;
      end
   end

   // pick the addressed lane out of the returned word
   always_comb begin
      case (track_m.addr_lo)
         2'd0: lane_b = data_rdata_m[7:0];
         2'd1: lane_b = data_rdata_m[15:8];
         2'd2: lane_b = data_rdata_m[23:16];
         default: lane_b = data_rdata_m[31:24];
      endcase
      lane_h = track_m.addr_lo[1] ? data_rdata_m[31:16] : data_rdata_m[15:0];
   end

   // extension bit, zero for the unsigned loads
   assign sign_b = ~track_m.access.zext & lane_b[7];
   assign sign_h = ~track_m.access.zext & lane_h[15];

   always_comb begin
      if (track_m.access.sc) begin
         read_result_m = {{(`LSU_GRLEN-1){1'b0}}, data_scsucceed};
      end else begin
         case (track_m.access.size)
            size_byte: read_result_m = {{(`LSU_GRLEN-8){sign_b}}, lane_b};
            size_half: read_result_m = {{(`LSU_GRLEN-16){sign_h}}, lane_h};
            default:   read_result_m = data_rdata_m;
         endcase
      end
   end

   // misaligned ops never reach memory, finish them right after dispatch
   assign lsu_finish_m  = data_data_ok_m | (valid_m & track_m.ale);
   assign lsu_ecl_rd_m  = track_m.rd;
   assign lsu_ecl_wen_m = track_m.wen;

   // no request was raised, so memory has nothing to return
   a_no_ok_on_ale: assert property (
      @(posedge clk) disable iff (reset)
      valid_m && track_m.ale |-> !data_data_ok_m
   ) else $error("data return for an operation that raised an alignment exception");

endmodule

// ==== hw/cpu7_lsu.sv ====
`include "lsu_config.svh"

module cpu7_lsu
   import lsu_op_pkg::*;
   import lsu_mem_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,

   input  logic                      valid_e,
   input  lsu_op_e                   lsu_op,
   input  logic [`LSU_GRLEN-1:0]     base,
   input  logic [`LSU_GRLEN-1:0]     offset,
   input  logic [`LSU_GRLEN-1:0]     wdata,
   input  logic [`LSU_RD_BITS-1:0]   ecl_lsu_rd_e,
   input  logic                      ecl_lsu_wen_e,

   // data memory port
   output logic                      data_req,
   output logic [`LSU_GRLEN-1:0]     data_addr,
   output logic                      data_wr,
   output logic [`LSU_STRB_BITS-1:0] data_wstrb,
   output logic [`LSU_GRLEN-1:0]     data_wdata,
   output logic                      data_ll,
   output logic                      data_sc,
   input  logic                      data_addr_ok,
   output logic                      data_recv,
   input  logic                      data_scsucceed,
   input  logic [`LSU_GRLEN-1:0]     data_rdata_m,
   input  logic                      data_data_ok_m,

   // results back to the pipeline
   output logic                      lsu_addr_finish,
   output logic [`LSU_GRLEN-1:0]     read_result_m,
   output logic                      lsu_finish_m,
   output logic [`LSU_RD_BITS-1:0]   lsu_ecl_rd_m,
   output logic                      lsu_ecl_wen_m,
   output logic                      lsu_ecl_ale_e,
   output logic [`LSU_GRLEN-1:0]     lsu_csr_badv_e
);

   lsu_access_t  access_e;
   lsu_mem_req_t mem_req_e;
   lsu_mem_req_t mem_req_q;
   lsu_track_t   track_e;
   logic         ale_e;

   lsu_issue lsu_issue_i (
      .lsu_op  (lsu_op),
      .base    (base),
      .offset  (offset),
      .wdata   (wdata),
      .access  (access_e),
      .mem_req (mem_req_e),
      .ale     (ale_e)
   );

   lsu_mem_request lsu_mem_request_i (
      .clk             (clk),
      .reset           (reset),
      .valid_e         (valid_e),
      .ale_e           (ale_e),
      .mem_req_e       (mem_req_e),
      .data_addr_ok    (data_addr_ok),
      .data_data_ok_m  (data_data_ok_m),
      .data_req        (data_req),
      .mem_req         (mem_req_q),
      .data_recv       (data_recv),
      .lsu_addr_finish (lsu_addr_finish)
   );

   // what the memory stage needs to finish the operation
   assign track_e.access  = access_e;
   assign track_e.addr_lo = mem_req_e.addr[1:0];
   assign track_e.rd      = ecl_lsu_rd_e;
   assign track_e.wen     = ecl_lsu_wen_e;
   assign track_e.ale     = ale_e;

   lsu_writeback lsu_writeback_i (
      .clk            (clk),
      .reset          (reset),
      .valid_e        (valid_e),
      .track_e        (track_e),
      .data_data_ok_m (data_data_ok_m),
      .data_rdata_m   (data_rdata_m),
      .data_scsucceed (data_scsucceed),
      .read_result_m  (read_result_m),
      .lsu_finish_m   (lsu_finish_m),
      .lsu_ecl_rd_m   (lsu_ecl_rd_m),
      .lsu_ecl_wen_m  (lsu_ecl_wen_m)
   );

   assign data_addr  = mem_req_q.addr;
   assign data_wr    = mem_req_q.wr;
   assign data_wstrb = mem_req_q.strb;
   assign data_wdata = mem_req_q.wdata;
   assign data_ll    = mem_req_q.ll;
   assign data_sc    = mem_req_q.sc;

   // exception is only meaningful in the dispatch cycle
   assign lsu_ecl_ale_e  = ale_e & valid_e;
   assign lsu_csr_badv_e = mem_req_e.addr;

endmodule

// ==== testbench/tb_cpu7_lsu.sv ====
`include "lsu_config.svh"

module tb_cpu7_lsu
   import lsu_op_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int num_ops        = 22;
   localparam int mem_words      = 16;
   localparam int timeout_cycles = 40;
   localparam logic [31:0] lfsr_taps = 32'h80200003;

   typedef enum logic [1:0] {ms_idle, ms_addr, ms_data, ms_done} mem_state_e;

   // expected strobes and write data are zero for loads and misaligned ops
   typedef struct packed {
      lsu_op_e     op;
      logic [31:0] base;
      logic [31:0] offset;
      logic [31:0] wdata;
      logic [4:0]  rd;
      logic        wen;
      logic [3:0]  strb;
      logic [31:0] wdata_exp;
      logic        ale;
      logic        sc_ok;
   } stim_t;

   logic                      clk = 1'b0;
   logic                      reset = 1'b1;
   logic                      valid_e = 1'b0;
   lsu_op_e                   lsu_op = nop;
   logic [`LSU_GRLEN-1:0]     base = '0;
   logic [`LSU_GRLEN-1:0]     offset = '0;
   logic [`LSU_GRLEN-1:0]     wdata = '0;
   logic [`LSU_RD_BITS-1:0]   ecl_lsu_rd_e = '0;
   logic                      ecl_lsu_wen_e = 1'b0;
   logic                      data_addr_ok = 1'b0;
   logic                      data_scsucceed = 1'b0;
   logic [`LSU_GRLEN-1:0]     data_rdata_m = '0;
   logic                      data_data_ok_m = 1'b0;
   logic                      data_req;
   logic [`LSU_GRLEN-1:0]     data_addr;
   logic                      data_wr;
   logic [`LSU_STRB_BITS-1:0] data_wstrb;
   logic [`LSU_GRLEN-1:0]     data_wdata;
   logic                      data_ll;
   logic                      data_sc;
   logic                      data_recv;
   logic                      lsu_addr_finish;
   logic [`LSU_GRLEN-1:0]     read_result_m;
   logic                      lsu_finish_m;
   logic [`LSU_RD_BITS-1:0]   lsu_ecl_rd_m;
   logic                      lsu_ecl_wen_m;
   logic                      lsu_ecl_ale_e;
   logic [`LSU_GRLEN-1:0]     lsu_csr_badv_e;

   logic [31:0] mem [0:mem_words-1];
   mem_state_e  m_state = ms_idle;
   logic [1:0]  m_cnt = 2'd0;
   logic [1:0]  dly;
   logic        fire_data;
   logic [31:0] lfsr = 32'hfc2c;
   logic        sc_ok_cur = 1'b0;
   int          cur_op = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          ops_done = 0;
   logic        timed_out = 1'b0;

   // op, base, offset, wdata, rd, wen, strb, wdata_exp, ale, sc_ok
   stim_t stim [0:num_ops-1] = '{
      '{st_w,  32'h10, 32'h4, 32'h12345678, 5'd0,  1'b0, 4'hf, 32'h12345678, 1'b0, 1'b0},
      '{ld_w,  32'h14, 32'h0, 32'h00000000, 5'd3,  1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{ld_b,  32'h14, 32'h3, 32'h00000000, 5'd4,  1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{ld_bu, 32'h14, 32'h2, 32'h00000000, 5'd5,  1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{ld_h,  32'h12, 32'h2, 32'h00000000, 5'd6,  1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{ld_hu, 32'h16, 32'h0, 32'h00000000, 5'd7,  1'b0, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{st_b,  32'h20, 32'h1, 32'h000000a5, 5'd0,  1'b0, 4'h2, 32'ha5a5a5a5, 1'b0, 1'b0},
      '{st_h,  32'h20, 32'h2, 32'h1234f00d, 5'd0,  1'b0, 4'hc, 32'hf00df00d, 1'b0, 1'b0},
      '{ld_b,  32'h20, 32'h1, 32'h00000000, 5'd8,  1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{ld_h,  32'h22, 32'h0, 32'h00000000, 5'd9,  1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{ld_h,  32'h31, 32'h0, 32'h00000000, 5'd10, 1'b1, 4'h0, 32'h00000000, 1'b1, 1'b0},
      '{ld_w,  32'h02, 32'h0, 32'h00000000, 5'd11, 1'b1, 4'h0, 32'h00000000, 1'b1, 1'b0},
      '{st_h,  32'h10, 32'h3, 32'h0000ffff, 5'd0,  1'b0, 4'h0, 32'h00000000, 1'b1, 1'b0},
      '{ll_w,  32'h14, 32'h0, 32'h00000000, 5'd12, 1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{sc_w,  32'h14, 32'h0, 32'hcafef00d, 5'd13, 1'b1, 4'hf, 32'hcafef00d, 1'b0, 1'b1},
      '{ld_w,  32'h14, 32'h0, 32'h00000000, 5'd14, 1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{sc_w,  32'h14, 32'h0, 32'h0bad0bad, 5'd15, 1'b1, 4'hf, 32'h0bad0bad, 1'b0, 1'b0},
      '{ld_w,  32'h24, 32'hfffffffc, 32'h0, 5'd16, 1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{ll_w,  32'h06, 32'h0, 32'h00000000, 5'd17, 1'b1, 4'h0, 32'h00000000, 1'b1, 1'b0},
      '{sc_w,  32'h0a, 32'h0, 32'h00000001, 5'd18, 1'b1, 4'h0, 32'h00000000, 1'b1, 1'b0},
      '{ld_hu, 32'h3c, 32'h0, 32'h00000000, 5'd19, 1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0},
      '{ld_bu, 32'h18, 32'h0, 32'h00000000, 5'd20, 1'b1, 4'h0, 32'h00000000, 1'b0, 1'b0}
   };

   cpu7_lsu cpu7_lsu_i (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ lfsr_taps;
      end
      return s >> 1;
   endfunction

   // two lfsr bits with one step per bit
   task draw_delay(output logic [1:0] d);
      d[0] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      d[1] = lfsr[0];
      lfsr = lfsr_step(lfsr);
   endtask

   function automatic logic [31:0] strb_mask(input logic [3:0] strb);
      return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
   endfunction

   // reference lane extraction and extension for a load
   function automatic logic [31:0] load_ref(input lsu_op_e op, input logic [31:0] word,
                                            input logic [1:0] lo);
      logic [31:0] sh;
      sh = word >> (8 * lo);
      case (op)
         ld_b:    return {{24{sh[7]}}, sh[7:0]};
         ld_bu:   return {24'd0, sh[7:0]};
         ld_h:    return {{16{sh[15]}}, sh[15:0]};
         ld_hu:   return {16'd0, sh[15:0]};
         default: return word;
      endcase
   endfunction

   // memory model with random addr_ok and data_ok delays
   always @(posedge clk) begin
      fire_data = 1'b0;
      data_addr_ok   <= 1'b0;
      data_data_ok_m <= 1'b0;
      if (reset) begin
         m_state <= ms_idle;
         m_cnt   <= 2'd0;
         // every byte differs with its own address
         for (int i = 0; i < mem_words; i++) begin
            mem[4'(i)] <= (32'(i) * 32'h04040404 + 32'h03020100) ^ 32'h5a3c96e1;
         end
      end else begin
         case (m_state)
            ms_idle: begin
               if (data_req) begin
                  draw_delay(dly);
                  m_cnt   <= dly;
                  m_state <= ms_addr;
               end
            end
            ms_addr: begin
               if (m_cnt == 2'd0) begin
                  data_addr_ok <= 1'b1;
                  draw_delay(dly);
                  if (dly == 2'd0) begin
                     fire_data = 1'b1;
                  end else begin
                     m_cnt   <= dly - 2'd1;
                     m_state <= ms_data;
                  end
               end else begin
                  m_cnt <= m_cnt - 2'd1;
               end
            end
            ms_data: begin
               if (m_cnt == 2'd0) begin
                  fire_data = 1'b1;
               end else begin
                  m_cnt <= m_cnt - 2'd1;
               end
            end
            default: m_state <= ms_idle;
         endcase
         if (fire_data) begin
            m_state        <= ms_done;
            data_data_ok_m <= 1'b1;
            data_rdata_m   <= mem[data_addr[5:2]];
            data_scsucceed <= sc_ok_cur;
            // a failed sc leaves memory untouched
            if (data_wr && (!data_sc || sc_ok_cur)) begin
               mem[data_addr[5:2]] <= (mem[data_addr[5:2]] & ~strb_mask(data_wstrb)) |
                                      (data_wdata & strb_mask(data_wstrb));
            end
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         value_errors++;
         $display("CHECK FAILED %s: got %h, expected %h (op %0d)", name, got, exp, cur_op);
      end
   endtask

   task automatic run_op(input int n);
      stim_t       s;
      logic [31:0] addr;
      logic [31:0] word;
      logic [31:0] exp_word;
      logic [31:0] exp_res;
      logic        exp_wr;
      logic        recv_exp;
      logic        done;
      int          cycles;

      s        = stim[n];
      addr     = s.base + s.offset;
      word     = mem[addr[5:2]];
      exp_wr   = s.op inside {st_b, st_h, st_w, sc_w};
      exp_word = word;
      if (exp_wr && (s.op != sc_w || s.sc_ok)) begin
         exp_word = (word & ~strb_mask(s.strb)) | (s.wdata_exp & strb_mask(s.strb));
      end
      exp_res = (s.op == sc_w) ? 32'(s.sc_ok) : load_ref(s.op, word, addr[1:0]);

      @(posedge clk);
      valid_e       <= 1'b1;
      lsu_op        <= s.op;
      base          <= s.base;
      offset        <= s.offset;
      wdata         <= s.wdata;
      ecl_lsu_rd_e  <= s.rd;
      ecl_lsu_wen_e <= s.wen;
      sc_ok_cur     <= s.sc_ok;
      @(negedge clk);
      check_value("data_req", 32'(data_req), 32'd0);
      check_value("data_recv", 32'(data_recv), 32'd0);
      check_value("lsu_ecl_ale_e", 32'(lsu_ecl_ale_e), 32'(s.ale));
      check_value("lsu_csr_badv_e", lsu_csr_badv_e, addr);
      @(posedge clk);
      valid_e <= 1'b0;

      recv_exp = 1'b0;
      done     = 1'b0;
      cycles   = 0;
      while (!done && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
         if (s.ale) begin
            // finish exactly one cycle after dispatch and never raise a request
            check_value("data_req", 32'(data_req), 32'd0);
            check_value("lsu_finish_m", 32'(lsu_finish_m), 32'(cycles == 1));
            if (cycles == 1) begin
               check_value("lsu_ecl_rd_m", 32'(lsu_ecl_rd_m), 32'(s.rd));
               check_value("lsu_ecl_wen_m", 32'(lsu_ecl_wen_m), 32'(s.wen));
            end
            done = (cycles == 2);
         end else begin
            check_value("data_req", 32'(data_req), 32'd1);
            check_value("data_addr", data_addr, addr);
            check_value("data_wr", 32'(data_wr), 32'(exp_wr));
            check_value("data_wstrb", 32'(data_wstrb), 32'(s.strb));
            check_value("data_wdata", data_wdata, s.wdata_exp);
            check_value("data_ll", 32'(data_ll), 32'(s.op == ll_w));
            check_value("data_sc", 32'(data_sc), 32'(s.op == sc_w));
            check_value("data_recv", 32'(data_recv), 32'(recv_exp));
            check_value("lsu_addr_finish", 32'(lsu_addr_finish), 32'(data_addr_ok));
            check_value("lsu_finish_m", 32'(lsu_finish_m), 32'(data_data_ok_m));
            if (data_data_ok_m) begin
               if (!exp_wr || s.op == sc_w) begin
                  check_value("read_result_m", read_result_m, exp_res);
               end
               check_value("lsu_ecl_rd_m", 32'(lsu_ecl_rd_m), 32'(s.rd));
               check_value("lsu_ecl_wen_m", 32'(lsu_ecl_wen_m), 32'(s.wen));
               check_value("memory word", mem[addr[5:2]], exp_word);
               done = 1'b1;
            end
            // accepted address stays outstanding until the return
            recv_exp = recv_exp | data_addr_ok;
         end
      end
      if (!done) begin
         other_errors++;
         timed_out = 1'b1;
         $display("timeout: operation %0d did not finish within %0d cycles", n, timeout_cycles);
      end
      ops_done++;
   endtask

   initial begin
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      for (int n = 0; n < num_ops; n++) begin
         cur_op = n;
         run_op(n);
         if (timed_out) begin
            break;
         end
      end
      $display("operations run: %0d, value errors: %0d, other errors: %0d",
               ops_done, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/lsu_op_pkg.sv
hw/lsu_mem_pkg.sv
hw/lsu_op_decode.sv
hw/lsu_issue.sv
hw/lsu_mem_request.sv
hw/lsu_writeback.sv
hw/cpu7_lsu.sv
testbench/tb_cpu7_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_cpu7_lsu -f filelist.f -o tb_cpu7_lsu \
   && ./obj_dir/tb_cpu7_lsu > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
